/* Makefile */
SIM      = verilator
SIMFLAGS = --binary --timing -j 0
TOP      = tb_platformer_core
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(SIM) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* block_contact.sv */
`timescale 1ns/1ps

module block_contact (
    input  logic           clk,
    input  logic           rst_i,
    input  geom_pkg::x_t   pos_x_i,
    input  geom_pkg::y_t   pos_y_i,
    output ctrl_pkg::dir_t contact_o
);

    ctrl_pkg::dir_t contact_next;

    always_comb begin
        int   px;
        int   py;
        int   pr;
        int   pb;
        int   bx;
        int   by;
        int   br;
        int   bb;
        logic h_ovl;
        logic v_ovl;

        // player box edges, inclusive
        px = int'(pos_x_i);
        py = int'(pos_y_i);
        pr = px + geom_pkg::PLAYER_W - 1;
        pb = py + geom_pkg::PLAYER_H - 1;

        contact_next = '0;
        // screen edge blocks further left moves
        contact_next[ctrl_pkg::DIR_LEFT] = (px == 0);

        for (int i = 0; i < geom_pkg::BLOCK_COUNT; i++) begin
            bx = int'(geom_pkg::BLOCK_X[i]);
            by = int'(geom_pkg::BLOCK_Y[i]);
            br = bx + geom_pkg::BLOCK_W - 1;
            bb = by + geom_pkg::BLOCK_H - 1;
            h_ovl = (px <= br) && (bx <= pr);
            v_ovl = (py <= bb) && (by <= pb);

            // block directly below the feet
            if (by == pb + 1 && h_ovl) begin
                contact_next[ctrl_pkg::DIR_DOWN] = 1'b1;
            end
            // block directly above the head
            if (bb + 1 == py && h_ovl) begin
                contact_next[ctrl_pkg::DIR_UP] = 1'b1;
            end
            if (pr + 1 == bx && v_ovl) begin
                contact_next[ctrl_pkg::DIR_RIGHT] = 1'b1;
            end
            if (br + 1 == px && v_ovl) begin
                contact_next[ctrl_pkg::DIR_LEFT] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            contact_o <= '0;
        end else begin
            contact_o <= contact_next;
        end
    end

endmodule

/* compile.f */
geom_pkg.sv
ctrl_pkg.sv
key_decoder.sv
block_contact.sv
motion_engine.sv
pickup_scorer.sv
platformer_core.sv
tb_platformer_core.sv

/* ctrl_pkg.sv */
package ctrl_pkg;

    // keyboard scan codes (set 2)
    localparam logic [7:0] KEY_W = 8'h1D;
    localparam logic [7:0] KEY_A = 8'h1C;
    localparam logic [7:0] KEY_D = 8'h23;
    localparam logic [7:0] KEY_R = 8'h2D;

    localparam int TIMER_W = 10;
    typedef logic [TIMER_W-1:0] timer_t;

    // contact vector and its bit positions
    typedef logic [3:0] dir_t;
    localparam int DIR_DOWN  = 0;
    localparam int DIR_UP    = 1;
    localparam int DIR_RIGHT = 2;
    localparam int DIR_LEFT  = 3;

    // all timing in motion ticks per pixel
    localparam timer_t H_STEP     = 10'd126;
    localparam timer_t JUMP_START = 10'd25;
    localparam timer_t JUMP_INC   = 10'd5;
    localparam timer_t JUMP_END   = 10'd50;
    localparam timer_t FALL_START = 10'd50;
    localparam timer_t FALL_DEC   = 10'd5;
    localparam timer_t FALL_MIN   = 10'd20;

    // pixels between two speed changes
    localparam int SPEED_GROUP = 24;

endpackage

/* geom_pkg.sv */
package geom_pkg;

    // screen coordinates
    typedef logic [9:0] x_t;
    typedef logic [8:0] y_t;

    typedef logic [3:0] score_t;

    // sprite box sizes in pixels
    localparam int PLAYER_W = 47;
    localparam int PLAYER_H = 33;
    localparam int BLOCK_W  = 28;
    localparam int BLOCK_H  = 42;
    localparam int SNOW_W   = 24;
    localparam int SNOW_H   = 26;

    // player bottom row sits on top of the ground row here
    localparam x_t SPAWN_X = 10'd0;
    localparam y_t SPAWN_Y = 9'd367;

    // ground row of 22 blocks, then one wall block
    localparam int BLOCK_COUNT = 23;
    localparam x_t BLOCK_X [0:BLOCK_COUNT-1] = '{
        10'd0,   10'd25,  10'd50,  10'd75,  10'd100, 10'd125, 10'd150, 10'd175,
        10'd200, 10'd225, 10'd250, 10'd275, 10'd300, 10'd325, 10'd350, 10'd375,
        10'd400, 10'd425, 10'd450, 10'd475, 10'd500, 10'd525, 10'd300
    };
    localparam y_t BLOCK_Y [0:BLOCK_COUNT-1] = '{
        9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400,
        9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400,
        9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd358
    };

    // snowflake corners
    localparam int SNOW_COUNT = 3;
    localparam x_t SNOW_X [0:SNOW_COUNT-1] = '{10'd60, 10'd150, 10'd400};
    localparam y_t SNOW_Y [0:SNOW_COUNT-1] = '{9'd370, 9'd370, 9'd370};

endpackage

/* key_decoder.sv */
`timescale 1ns/1ps

module key_decoder (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       key_valid_i,
    input  logic [7:0] key_code_i,
    input  logic       key_break_i,
    output logic       up_held_o,
    output logic       left_held_o,
    output logic       right_held_o,
    output logic       reset_held_o
);

    // make sets the flag, break clears it
    always_ff @(posedge clk) begin
        if (rst_i) begin
            up_held_o    <= 1'b0;
            left_held_o  <= 1'b0;
            right_held_o <= 1'b0;
            reset_held_o <= 1'b0;
        end else if (key_valid_i) begin
            case (key_code_i)
                ctrl_pkg::KEY_W: begin
                    up_held_o <= ~key_break_i;
                end
                ctrl_pkg::KEY_A: begin
                    left_held_o <= ~key_break_i;
                end
                ctrl_pkg::KEY_D: begin
                    right_held_o <= ~key_break_i;
                end
                ctrl_pkg::KEY_R: begin
                    reset_held_o <= ~key_break_i;
                end
                default: begin
                    // other keys are not used by the core
                end
            endcase
        end
    end

endmodule

/* motion_engine.sv */
`timescale 1ns/1ps

module motion_engine #(
    parameter int unsigned TICK_DIV = 10000
) (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           up_held_i,
    input  logic           left_held_i,
    input  logic           right_held_i,
    input  logic           reset_held_i,
    input  ctrl_pkg::dir_t contact_i,
    output geom_pkg::x_t   pos_x_o,
    output geom_pkg::y_t   pos_y_o,
    output logic           facing_right_o,
    output logic           moving_o,
    output logic           in_air_o
);

    localparam int TICK_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam int GRP_W  = $clog2(ctrl_pkg::SPEED_GROUP);

    logic [TICK_W-1:0] tick_cnt;
    logic              tick;

    ctrl_pkg::timer_t  h_cnt;
    ctrl_pkg::timer_t  v_cnt;
    ctrl_pkg::timer_t  jump_timer;
    ctrl_pkg::timer_t  fall_timer;
    logic [GRP_W-1:0]  grp_cnt;
    logic              grp_last;

    logic              jumping;
    logic              jump_next;
    logic              go_left;
    logic              go_right;

    // motion tick every TICK_DIV clocks
    assign tick = (tick_cnt == TICK_W'(TICK_DIV - 1));

    always_ff @(posedge clk) begin
        if (rst_i || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // left wins only when right is not held
    assign go_left  = left_held_i && !right_held_i && !contact_i[ctrl_pkg::DIR_LEFT];
    assign go_right = right_held_i && !contact_i[ctrl_pkg::DIR_RIGHT];

    assign grp_last = (grp_cnt == GRP_W'(ctrl_pkg::SPEED_GROUP - 1));

    // ceiling or slowest jump speed ends the rise
    always_comb begin
        if (contact_i[ctrl_pkg::DIR_UP] || jump_timer >= ctrl_pkg::JUMP_END) begin
            jump_next = 1'b0;
        end else if (up_held_i && contact_i[ctrl_pkg::DIR_DOWN]) begin
            jump_next = 1'b1;
        end else begin
            jump_next = jumping;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pos_x_o        <= geom_pkg::SPAWN_X;
            pos_y_o        <= geom_pkg::SPAWN_Y;
            facing_right_o <= 1'b0;
            moving_o       <= 1'b0;
            in_air_o       <= 1'b0;
            jumping        <= 1'b0;
            h_cnt          <= '0;
            v_cnt          <= '0;
            grp_cnt        <= '0;
            jump_timer     <= ctrl_pkg::JUMP_START;
            fall_timer     <= ctrl_pkg::FALL_START;
        end else if (tick) begin
            in_air_o <= ~contact_i[ctrl_pkg::DIR_DOWN];
            if (reset_held_i) begin
                // back to spawn with motion state cleared
                pos_x_o    <= geom_pkg::SPAWN_X;
                pos_y_o    <= geom_pkg::SPAWN_Y;
                moving_o   <= 1'b0;
                jumping    <= 1'b0;
                h_cnt      <= '0;
                v_cnt      <= '0;
                grp_cnt    <= '0;
                jump_timer <= ctrl_pkg::JUMP_START;
                fall_timer <= ctrl_pkg::FALL_START;
            end else begin
                // horizontal stepping
                if (go_left || go_right) begin
                    facing_right_o <= go_right;
                    moving_o       <= 1'b1;
                    if (h_cnt < ctrl_pkg::H_STEP) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt <= '0;
                        if (go_left) begin
                            pos_x_o <= pos_x_o - 1'b1;
                        end else begin
                            pos_x_o <= pos_x_o + 1'b1;
                        end
                    end
                end else begin
                    moving_o <= 1'b0;
                end

                // vertical rise, fall or stand
                jumping <= jump_next;
                if (jump_next) begin
                    fall_timer <= ctrl_pkg::FALL_START;
                    if (v_cnt < jump_timer) begin
                        v_cnt <= v_cnt + 1'b1;
                    end else begin
                        v_cnt   <= '0;
                        pos_y_o <= pos_y_o - 1'b1;
                        grp_cnt <= grp_last ? '0 : grp_cnt + 1'b1;
                        // slow the rise
                        if (grp_last) begin
                            jump_timer <= jump_timer + ctrl_pkg::JUMP_INC;
                        end
                    end
                end else if (!contact_i[ctrl_pkg::DIR_DOWN]) begin
                    jump_timer <= ctrl_pkg::JUMP_START;
                    if (jumping) begin
                        // fall starts fresh at the top of the arc
                        v_cnt   <= '0;
                        grp_cnt <= '0;
                    end else if (v_cnt < fall_timer) begin
                        v_cnt <= v_cnt + 1'b1;
                    end else begin
                        v_cnt   <= '0;
                        pos_y_o <= pos_y_o + 1'b1;
                        grp_cnt <= grp_last ? '0 : grp_cnt + 1'b1;
                        // speed up but not past FALL_MIN
                        if (grp_last) begin
                            if (fall_timer >= ctrl_pkg::FALL_MIN + ctrl_pkg::FALL_DEC) begin
                                fall_timer <= fall_timer - ctrl_pkg::FALL_DEC;
                            end else begin
                                fall_timer <= ctrl_pkg::FALL_MIN;
                            end
                        end
                    end
                end else begin
                    // timers reload while standing
                    v_cnt      <= '0;
                    grp_cnt    <= '0;
                    jump_timer <= ctrl_pkg::JUMP_START;
                    fall_timer <= ctrl_pkg::FALL_START;
                end
            end
        end
    end

endmodule

/* pickup_scorer.sv */
`timescale 1ns/1ps

module pickup_scorer (
    input  logic             clk,
    input  logic             rst_i,
    input  geom_pkg::x_t     pos_x_i,
    input  geom_pkg::y_t     pos_y_i,
    output geom_pkg::score_t score_o,
    output logic             pickup_o
);

    logic [geom_pkg::SNOW_COUNT-1:0] collected;
    logic [geom_pkg::SNOW_COUNT-1:0] hit;
    geom_pkg::score_t                hit_cnt;

    // box overlap against every snowflake not yet taken
    always_comb begin
        int px;
        int py;
        int sx;
        int sy;

        px = int'(pos_x_i);
        py = int'(pos_y_i);
        hit_cnt = '0;
        for (int i = 0; i < geom_pkg::SNOW_COUNT; i++) begin
            sx = int'(geom_pkg::SNOW_X[i]);
            sy = int'(geom_pkg::SNOW_Y[i]);
            hit[i] = !collected[i]
                  && (px <= sx + geom_pkg::SNOW_W - 1)
                  && (sx <= px + geom_pkg::PLAYER_W - 1)
                  && (py <= sy + geom_pkg::SNOW_H - 1)
                  && (sy <= py + geom_pkg::PLAYER_H - 1);
            if (hit[i]) begin
                hit_cnt = hit_cnt + 1'b1;
            end
        end
    end

    // flake is gone once collected, so each pickup pulses once
    always_ff @(posedge clk) begin
        if (rst_i) begin
            collected <= '0;
            score_o   <= '0;
            pickup_o  <= 1'b0;
        end else begin
            collected <= collected | hit;
            score_o   <= score_o + hit_cnt;
            pickup_o  <= |hit;
        end
    end

endmodule

/* platformer_core.sv */
`timescale 1ns/1ps

module platformer_core #(
    parameter int unsigned TICK_DIV = 10000
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             key_valid_i,
    input  logic [7:0]       key_code_i,
    input  logic             key_break_i,
    output geom_pkg::x_t     pos_x_o,
    output geom_pkg::y_t     pos_y_o,
    output logic             facing_right_o,
    output logic             moving_o,
    output logic             in_air_o,
    output geom_pkg::score_t score_o,
    output logic             pickup_o
);

    logic           up_held;
    logic           left_held;
    logic           right_held;
    logic           reset_held;
    ctrl_pkg::dir_t contact;

    key_decoder u_key_decoder (
        .clk          (clk),
        .rst_i        (rst_i),
        .key_valid_i  (key_valid_i),
        .key_code_i   (key_code_i),
        .key_break_i  (key_break_i),
        .up_held_o    (up_held),
        .left_held_o  (left_held),
        .right_held_o (right_held),
        .reset_held_o (reset_held)
    );

    block_contact u_block_contact (
        .clk       (clk),
        .rst_i     (rst_i),
        .pos_x_i   (pos_x_o),
        .pos_y_i   (pos_y_o),
        .contact_o (contact)
    );

    motion_engine #(
        .TICK_DIV (TICK_DIV)
    ) u_motion_engine (
        .clk            (clk),
        .rst_i          (rst_i),
        .up_held_i      (up_held),
        .left_held_i    (left_held),
        .right_held_i   (right_held),
        .reset_held_i   (reset_held),
        .contact_i      (contact),
        .pos_x_o        (pos_x_o),
        .pos_y_o        (pos_y_o),
        .facing_right_o (facing_right_o),
        .moving_o       (moving_o),
        .in_air_o       (in_air_o)
    );

    pickup_scorer u_pickup_scorer (
        .clk      (clk),
        .rst_i    (rst_i),
        .pos_x_i  (pos_x_o),
        .pos_y_i  (pos_y_o),
        .score_o  (score_o),
        .pickup_o (pickup_o)
    );

endmodule

/* tb_platformer_core.sv */
`timescale 1ns/1ps

module tb_platformer_core;

    localparam int    CLK_HALF  = 2;
    localparam int    TICK_DIV  = 2;
    localparam string STIM_FILE = "test_input.txt";
    // headroom on top of the summed waits
    localparam int    WD_MARGIN = 2000;

    logic             clk;
    logic             rst_i;
    logic             key_valid_i;
    logic [7:0]       key_code_i;
    logic             key_break_i;
    geom_pkg::x_t     pos_x_o;
    geom_pkg::y_t     pos_y_o;
    logic             facing_right_o;
    logic             moving_o;
    logic             in_air_o;
    geom_pkg::score_t score_o;
    logic             pickup_o;

    int   min_y         = 1000;
    int   budget_cycles = 0;
    int   pickups       = 0;
    logic air_seen      = 1'b0;
    logic exp_facing    = 1'b0;
    logic left_down     = 1'b0;
    logic right_down    = 1'b0;

    platformer_core #(
        .TICK_DIV (TICK_DIV)
    ) u_dut (
        .clk            (clk),
        .rst_i          (rst_i),
        .key_valid_i    (key_valid_i),
        .key_code_i     (key_code_i),
        .key_break_i    (key_break_i),
        .pos_x_o        (pos_x_o),
        .pos_y_o        (pos_y_o),
        .facing_right_o (facing_right_o),
        .moving_o       (moving_o),
        .in_air_o       (in_air_o),
        .score_o        (score_o),
        .pickup_o       (pickup_o)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    // lowest y, airborne flag and pickup pulses since the last check
    always @(negedge clk) begin
        if (int'(pos_y_o) < min_y) begin
            min_y = int'(pos_y_o);
        end
        if (in_air_o === 1'b1) begin
            air_seen = 1'b1;
        end
        if (pickup_o === 1'b1) begin
            pickups = pickups + 1;
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %0d actual %0d", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    // held direction keys and the facing they imply
    task automatic track_keys(input logic [7:0] code, input logic brk);
        if (code == ctrl_pkg::KEY_A) begin
            left_down = !brk;
            if (!brk) begin
                exp_facing = 1'b0;
            end
        end else if (code == ctrl_pkg::KEY_D) begin
            right_down = !brk;
            if (!brk) begin
                exp_facing = 1'b1;
            end
        end
    endtask

    // one-cycle strobe followed by a short random idle gap
    task automatic send_key(input logic [7:0] code, input logic brk);
        int gap;
        track_keys(code, brk);
        @(posedge clk);
        key_valid_i <= 1'b1;
        key_code_i  <= code;
        key_break_i <= brk;
        @(posedge clk);
        key_valid_i <= 1'b0;
        gap = int'($urandom % 4);
        repeat (gap) @(posedge clk);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // first pass over the file sizes the watchdog
    task automatic count_budget();
        int    fd;
        int    r;
        int    val;
        int    total;
        string cmd;
        string rest;
        total = WD_MARGIN;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run({"cannot open stimulus file ", STIM_FILE});
        end else begin
            r = $fscanf(fd, "%s", cmd);
            while (r == 1) begin
                if (cmd == "W") begin
                    r = $fscanf(fd, "%d", val);
                    total = total + val;
                end else begin
                    r = $fgets(rest, fd);
                    // strobe plus worst-case gap or one check slot
                    total = total + ((cmd == "K") ? 8 : 2);
                end
                r = $fscanf(fd, "%s", cmd);
            end
            $fclose(fd);
            budget_cycles = total;
        end
    endtask

    task automatic run_check(input string cmd, input int val, input string name);
        int low_y;
        @(negedge clk);
        low_y = (int'(pos_y_o) < min_y) ? int'(pos_y_o) : min_y;
        if (cmd == "X") begin
            check_value(name, val, int'(pos_x_o));
            check_value({name, "_facing"}, int'(exp_facing), int'(facing_right_o));
            if (!left_down && !right_down) begin
                check_value({name, "_moving"}, 0, int'(moving_o));
            end
        end else if (cmd == "Y") begin
            check_value(name, val, int'(pos_y_o));
        end else if (cmd == "S") begin
            check_value(name, val, int'(score_o));
            // one pulse per collected flake
            check_value({name, "_pickups"}, val, pickups);
        end else begin
            // apex must reach the bound or go higher on screen
            check_value(name, val, (low_y <= val) ? val : low_y);
            check_value({name, "_in_air"}, 1, int'(air_seen));
        end
        min_y    = int'(pos_y_o);
        air_seen = (in_air_o === 1'b1);
    endtask

    task automatic run_file();
        int    fd;
        int    r;
        int    val;
        int    brk;
        string cmd;
        string name;
        string rest;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run({"cannot reopen stimulus file ", STIM_FILE});
        end else begin
            r = $fscanf(fd, "%s", cmd);
            while (r == 1) begin
                if (cmd == "#") begin
                    r = $fgets(rest, fd);
                end else if (cmd == "K") begin
                    r = $fscanf(fd, "%h %d", val, brk);
                    send_key(8'(val), brk[0]);
                end else if (cmd == "W") begin
                    r = $fscanf(fd, "%d", val);
                    wait_cycles(val);
                end else if (cmd == "X" || cmd == "Y" || cmd == "S" || cmd == "P") begin
                    r = $fscanf(fd, "%d %s", val, name);
                    run_check(cmd, val, name);
                end else begin
                    abort_run({"unknown command in stimulus file: ", cmd});
                end
                r = $fscanf(fd, "%s", cmd);
            end
            $fclose(fd);
        end
    endtask

    initial begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, stimulus did not finish", budget_cycles);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        rst_i       = 1'b1;
        key_valid_i = 1'b0;
        key_code_i  = 8'h00;
        key_break_i = 1'b0;
        void'($urandom(73));
        count_budget();
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_value("reset_in_air", 0, int'(in_air_o));
        check_value("reset_facing", 0, int'(facing_right_o));
        check_value("reset_moving", 0, int'(moving_o));
        check_value("reset_pickup", 0, int'(pickup_o));
        min_y = int'(pos_y_o);
        run_file();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* test_input.txt */
# K <scan code hex> <break 0/1>    W <cycles to wait>
# X|Y|S <expected> <name>    P <bound for lowest y since last check> <name>
X 0 reset_x
Y 367 reset_y
S 0 reset_score
K 1C 0
W 600
K 1C 1
W 20
X 0 left_edge_x
K 1D 0
W 10
K 1D 1
W 24000
P 343 jump_apex
Y 367 jump_land_y
X 0 jump_land_x
K 23 0
W 70000
K 23 1
W 20
X 253 wall_stop_x
Y 367 wall_stop_y
S 2 walk_score
K 1C 0
W 70000
K 1C 1
W 20
X 0 walk_back_x
S 2 walk_back_score
K 23 0
W 10000
K 23 1
W 40
K 2D 0
W 40
K 2D 1
W 40
X 0 respawn_x
Y 367 respawn_y
S 2 respawn_score
